/* src/alu_pkg.sv */
package alu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int XLEN       = 32;
  localparam int PC_W       = 32;
  localparam int RFIDX_W    = 5;
  localparam int DECINFO_W  = 8;
  localparam int CODE_W     = 4;
  localparam int DPATH_OP_W = 5;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [PC_W-1:0]       pc_t;
  typedef logic [RFIDX_W-1:0]    rfidx_t;
  typedef logic [DECINFO_W-1:0]  decinfo_t;
  typedef logic [CODE_W-1:0]     alu_code_t;
  typedef logic [CODE_W-1:0]     bjp_code_t;
  typedef logic [DPATH_OP_W-1:0] dpath_op_t;

  ////////////////////////////////////////////////////////////
  // Decode info layout
  ////////////////////////////////////////////////////////////
  localparam int DECINFO_GRP_LSB = 0;
  localparam int DECINFO_GRP_W   = 2;
  localparam int DECINFO_OP_LSB  = 2;
  localparam int DECINFO_OP_W    = CODE_W;
  localparam int DECINFO_OP2IMM  = 6;
  localparam int DECINFO_BPRDT   = 7;

  // Groups 2 and 3 are reserved
  localparam logic [DECINFO_GRP_W-1:0] GRP_ALU = 2'd0;
  localparam logic [DECINFO_GRP_W-1:0] GRP_BJP = 2'd1;

  // Regular ALU codes, 11..15 fall back to add
  localparam alu_code_t ALU_ADD  = 4'd0;
  localparam alu_code_t ALU_SUB  = 4'd1;
  localparam alu_code_t ALU_XOR  = 4'd2;
  localparam alu_code_t ALU_SLL  = 4'd3;
  localparam alu_code_t ALU_SRL  = 4'd4;
  localparam alu_code_t ALU_SRA  = 4'd5;
  localparam alu_code_t ALU_OR   = 4'd6;
  localparam alu_code_t ALU_AND  = 4'd7;
  localparam alu_code_t ALU_SLT  = 4'd8;
  localparam alu_code_t ALU_SLTU = 4'd9;
  localparam alu_code_t ALU_LUI  = 4'd10;

  // Branch codes, 7..15 fall back to jal
  localparam bjp_code_t BJP_JAL  = 4'd0;
  localparam bjp_code_t BJP_BEQ  = 4'd1;
  localparam bjp_code_t BJP_BNE  = 4'd2;
  localparam bjp_code_t BJP_BLT  = 4'd3;
  localparam bjp_code_t BJP_BGE  = 4'd4;
  localparam bjp_code_t BJP_BLTU = 4'd5;
  localparam bjp_code_t BJP_BGEU = 4'd6;

  ////////////////////////////////////////////////////////////
  // Shared datapath operations
  ////////////////////////////////////////////////////////////
  localparam dpath_op_t DP_ADD  = 5'd0;
  localparam dpath_op_t DP_SUB  = 5'd1;
  localparam dpath_op_t DP_XOR  = 5'd2;
  localparam dpath_op_t DP_SLL  = 5'd3;
  localparam dpath_op_t DP_SRL  = 5'd4;
  localparam dpath_op_t DP_SRA  = 5'd5;
  localparam dpath_op_t DP_OR   = 5'd6;
  localparam dpath_op_t DP_AND  = 5'd7;
  localparam dpath_op_t DP_SLT  = 5'd8;
  localparam dpath_op_t DP_SLTU = 5'd9;
  localparam dpath_op_t DP_LUI  = 5'd10;
  // Compares return 1 or 0
  localparam dpath_op_t DP_EQ   = 5'd11;
  localparam dpath_op_t DP_NE   = 5'd12;
  localparam dpath_op_t DP_LT   = 5'd13;
  localparam dpath_op_t DP_GE   = 5'd14;
  localparam dpath_op_t DP_LTU  = 5'd15;
  localparam dpath_op_t DP_GEU  = 5'd16;

  // Instruction size for the link address
  localparam pc_t PC_STEP = 32'd4;

endpackage

/* src/alu_req_if.sv */
`timescale 1ns/1ps

interface alu_req_if;

  // Request side
  logic                 req;
  alu_pkg::dpath_op_t   op;
  alu_pkg::xlen_t       op1;
  alu_pkg::xlen_t       op2;
  // Result side, compares give 0 or 1
  alu_pkg::xlen_t       res;

  modport requester (
    output req,
    output op,
    output op1,
    output op2,
    input  res
  );

  modport dpath (
    input  req,
    input  op,
    input  op1,
    input  op2,
    output res
  );

endinterface

/* src/alu_dispatch.sv */
`timescale 1ns/1ps

module alu_dispatch (
  input  alu_pkg::decinfo_t i_info,
  input  logic              i_ilegl,
  input  alu_pkg::xlen_t    i_rs1,
  input  alu_pkg::xlen_t    i_rs2,
  input  alu_pkg::xlen_t    i_imm,
  input  alu_pkg::pc_t      i_pc,
  output logic              o_alu_sel,
  output logic              o_bjp_sel,
  output logic              o_excp,
  output alu_pkg::xlen_t    o_alu_rs1,
  output alu_pkg::xlen_t    o_alu_rs2,
  output alu_pkg::xlen_t    o_alu_imm,
  output alu_pkg::xlen_t    o_bjp_rs1,
  output alu_pkg::xlen_t    o_bjp_rs2,
  output alu_pkg::pc_t      o_bjp_pc
);

  logic [alu_pkg::DECINFO_GRP_W-1:0] grp;
  logic                              grp_alu;
  logic                              grp_bjp;

  ////////////////////////////////////////////////////////////
  // Group decode
  ////////////////////////////////////////////////////////////
  assign grp     = i_info[alu_pkg::DECINFO_GRP_LSB +: alu_pkg::DECINFO_GRP_W];
  assign grp_alu = (grp == alu_pkg::GRP_ALU);
  assign grp_bjp = (grp == alu_pkg::GRP_BJP);

  // Fetch-side illegal or reserved group goes down the exception path
  assign o_excp    = i_ilegl | ~(grp_alu | grp_bjp);
  // At most one unit, never both
  assign o_alu_sel = ~i_ilegl & grp_alu;
  assign o_bjp_sel = ~i_ilegl & grp_bjp;

  ////////////////////////////////////////////////////////////
  // Operand gating
  ////////////////////////////////////////////////////////////
  // Idle unit sees zeros, keeps its logic quiet
  assign o_alu_rs1 = {alu_pkg::XLEN{o_alu_sel}} & i_rs1;
  assign o_alu_rs2 = {alu_pkg::XLEN{o_alu_sel}} & i_rs2;
  assign o_alu_imm = {alu_pkg::XLEN{o_alu_sel}} & i_imm;

  assign o_bjp_rs1 = {alu_pkg::XLEN{o_bjp_sel}} & i_rs1;
  assign o_bjp_rs2 = {alu_pkg::XLEN{o_bjp_sel}} & i_rs2;
  assign o_bjp_pc  = {alu_pkg::PC_W{o_bjp_sel}} & i_pc;

endmodule

/* src/alu_rglr.sv */
`timescale 1ns/1ps

module alu_rglr (
  input  logic               i_sel,
  input  alu_pkg::alu_code_t i_code,
  input  logic               i_op2imm,
  input  alu_pkg::xlen_t     i_rs1,
  input  alu_pkg::xlen_t     i_rs2,
  input  alu_pkg::xlen_t     i_imm,
  alu_req_if.requester       o_req,
  output alu_pkg::xlen_t     o_wdat
);

  logic is_lui;

  // Code to datapath op
  always_comb begin
    case (i_code)
      alu_pkg::ALU_SUB:  o_req.op = alu_pkg::DP_SUB;
      alu_pkg::ALU_XOR:  o_req.op = alu_pkg::DP_XOR;
      alu_pkg::ALU_SLL:  o_req.op = alu_pkg::DP_SLL;
      alu_pkg::ALU_SRL:  o_req.op = alu_pkg::DP_SRL;
      alu_pkg::ALU_SRA:  o_req.op = alu_pkg::DP_SRA;
      alu_pkg::ALU_OR:   o_req.op = alu_pkg::DP_OR;
      alu_pkg::ALU_AND:  o_req.op = alu_pkg::DP_AND;
      alu_pkg::ALU_SLT:  o_req.op = alu_pkg::DP_SLT;
      alu_pkg::ALU_SLTU: o_req.op = alu_pkg::DP_SLTU;
      alu_pkg::ALU_LUI:  o_req.op = alu_pkg::DP_LUI;
      // ALU_ADD and the unused codes
      default:           o_req.op = alu_pkg::DP_ADD;
    endcase
  end

  assign is_lui = (i_code == alu_pkg::ALU_LUI);

  // LUI rides the adder as imm + 0
  assign o_req.op1 = is_lui ? i_imm : i_rs1;
  assign o_req.op2 = is_lui   ? '0 :
                     i_op2imm ? i_imm : i_rs2;

  assign o_req.req = i_sel;
  assign o_wdat    = o_req.res;

endmodule

/* src/alu_bjp.sv */
`timescale 1ns/1ps

module alu_bjp (
  input  logic               i_sel,
  input  alu_pkg::bjp_code_t i_code,
  input  logic               i_prdt,
  input  alu_pkg::xlen_t     i_rs1,
  input  alu_pkg::xlen_t     i_rs2,
  input  alu_pkg::pc_t       i_pc,
  alu_req_if.requester       o_req,
  output alu_pkg::xlen_t     o_wdat,
  output logic               o_cmt_bjp,
  output logic               o_cmt_prdt,
  output logic               o_cmt_rslv
);

  logic is_cond;

  ////////////////////////////////////////////////////////////
  // Compare request
  ////////////////////////////////////////////////////////////
  always_comb begin
    is_cond  = 1'b1;
    o_req.op = alu_pkg::DP_EQ;
    case (i_code)
      alu_pkg::BJP_BEQ:  o_req.op = alu_pkg::DP_EQ;
      alu_pkg::BJP_BNE:  o_req.op = alu_pkg::DP_NE;
      alu_pkg::BJP_BLT:  o_req.op = alu_pkg::DP_LT;
      alu_pkg::BJP_BGE:  o_req.op = alu_pkg::DP_GE;
      alu_pkg::BJP_BLTU: o_req.op = alu_pkg::DP_LTU;
      alu_pkg::BJP_BGEU: o_req.op = alu_pkg::DP_GEU;
      // JAL and codes past BGEU, unconditional
      default:           is_cond  = 1'b0;
    endcase
  end

  // Datapath only needed for a real compare
  assign o_req.req = i_sel & is_cond;
  assign o_req.op1 = i_rs1;
  assign o_req.op2 = i_rs2;

  ////////////////////////////////////////////////////////////
  // Link address and commit flags
  ////////////////////////////////////////////////////////////
  // Own adder, the shared one is busy with the compare
  assign o_wdat = i_pc + alu_pkg::PC_STEP;

  assign o_cmt_bjp  = i_sel;
  assign o_cmt_prdt = i_sel & i_prdt;
  assign o_cmt_rslv = i_sel & (is_cond ? o_req.res[0] : 1'b1);

endmodule

/* src/alu_dpath.sv */
`timescale 1ns/1ps

module alu_dpath (
  alu_req_if.dpath i_alu,
  alu_req_if.dpath i_bjp
);

  alu_pkg::dpath_op_t         op;
  alu_pkg::xlen_t             op1;
  alu_pkg::xlen_t             op2;
  alu_pkg::xlen_t             res;
  logic                       signed_cmp;
  logic                       unsigned_cmp;
  logic                       adder_sub;
  logic [alu_pkg::XLEN:0]     add_a;
  logic [alu_pkg::XLEN:0]     add_b;
  logic [alu_pkg::XLEN:0]     add_res;
  alu_pkg::xlen_t             xor_res;
  logic [4:0]                 shamt;
  logic                       lt;
  logic                       eq;

  ////////////////////////////////////////////////////////////
  // Requester mux
  ////////////////////////////////////////////////////////////
  // AND-OR mux, dispatch keeps the two reqs exclusive
  assign op  = ({alu_pkg::DPATH_OP_W{i_alu.req}} & i_alu.op)
             | ({alu_pkg::DPATH_OP_W{i_bjp.req}} & i_bjp.op);
  assign op1 = ({alu_pkg::XLEN{i_alu.req}} & i_alu.op1)
             | ({alu_pkg::XLEN{i_bjp.req}} & i_bjp.op1);
  assign op2 = ({alu_pkg::XLEN{i_alu.req}} & i_alu.op2)
             | ({alu_pkg::XLEN{i_bjp.req}} & i_bjp.op2);

  ////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////
  assign signed_cmp   = (op == alu_pkg::DP_SLT) | (op == alu_pkg::DP_LT)
                      | (op == alu_pkg::DP_GE);
  assign unsigned_cmp = (op == alu_pkg::DP_SLTU) | (op == alu_pkg::DP_LTU)
                      | (op == alu_pkg::DP_GEU);
  assign adder_sub    = (op == alu_pkg::DP_SUB) | signed_cmp | unsigned_cmp;

  // One extra bit, sign for signed compares, zero otherwise
  assign add_a = {signed_cmp & op1[alu_pkg::XLEN-1], op1};
  assign add_b = {signed_cmp & op2[alu_pkg::XLEN-1], op2};
  // Subtract as a + ~b + 1
  assign add_res = add_a + (add_b ^ {(alu_pkg::XLEN+1){adder_sub}})
                 + {{alu_pkg::XLEN{1'b0}}, adder_sub};

  // Top bit of the difference is the less-than flag
  assign lt = add_res[alu_pkg::XLEN];

  // Equality from the xor, not the adder
  assign xor_res = op1 ^ op2;
  assign eq      = (xor_res == '0);

  // RV32 shifts use five bits only
  assign shamt = op2[4:0];

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (op)
      alu_pkg::DP_XOR:  res = xor_res;
      alu_pkg::DP_SLL:  res = op1 << shamt;
      alu_pkg::DP_SRL:  res = op1 >> shamt;
      alu_pkg::DP_SRA:  res = $signed(op1) >>> shamt;
      alu_pkg::DP_OR:   res = op1 | op2;
      alu_pkg::DP_AND:  res = op1 & op2;
      alu_pkg::DP_SLT,
      alu_pkg::DP_SLTU,
      alu_pkg::DP_LT,
      alu_pkg::DP_LTU:  res = {{(alu_pkg::XLEN-1){1'b0}}, lt};
      alu_pkg::DP_GE,
      alu_pkg::DP_GEU:  res = {{(alu_pkg::XLEN-1){1'b0}}, ~lt};
      alu_pkg::DP_EQ:   res = {{(alu_pkg::XLEN-1){1'b0}}, eq};
      alu_pkg::DP_NE:   res = {{(alu_pkg::XLEN-1){1'b0}}, ~eq};
      // Add, sub and lui
      default:          res = add_res[alu_pkg::XLEN-1:0];
    endcase
  end

  // Same result to both, only the requester samples it
  assign i_alu.res = res;
  assign i_bjp.res = res;

endmodule

/* src/alu_wbck_cmt.sv */
`timescale 1ns/1ps

module alu_wbck_cmt (
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic            i_valid,
  output logic            o_ready,
  input  logic            i_alu_sel,
  input  logic            i_bjp_sel,
  input  logic            i_excp,
  input  alu_pkg::xlen_t  i_alu_wdat,
  input  alu_pkg::xlen_t  i_bjp_wdat,
  input  logic            i_bjp_cmt,
  input  logic            i_bjp_prdt,
  input  logic            i_bjp_rslv,
  input  logic            i_rdwen,
  input  alu_pkg::rfidx_t i_rdidx,
  input  alu_pkg::pc_t    i_pc,
  input  logic            i_pc_vld,
  input  alu_pkg::xlen_t  i_imm,
  output logic            o_cmt_valid,
  input  logic            i_cmt_ready,
  output logic            o_cmt_pc_vld,
  output alu_pkg::pc_t    o_cmt_pc,
  output alu_pkg::xlen_t  o_cmt_imm,
  output logic            o_cmt_bjp,
  output logic            o_cmt_bjp_prdt,
  output logic            o_cmt_bjp_rslv,
  output logic            o_cmt_ilegl,
  output logic            o_wbck_valid,
  input  logic            i_wbck_ready,
  output alu_pkg::xlen_t  o_wbck_wdat,
  output alu_pkg::rfidx_t o_wbck_rdidx
);

  alu_pkg::xlen_t wdat;
  logic           vld_q;
  logic           rdwen_q;
  logic           excp_q;
  logic           need_wbck;
  logic           accept;
  logic           retire;

  // Exception writes zero, else the selected unit
  assign wdat = i_excp ? '0 :
                ({alu_pkg::XLEN{i_alu_sel}} & i_alu_wdat)
              | ({alu_pkg::XLEN{i_bjp_sel}} & i_bjp_wdat);

  ////////////////////////////////////////////////////////////
  // Joint commit and write-back handshake
  ////////////////////////////////////////////////////////////
  assign need_wbck = rdwen_q & ~excp_q;

  // Each channel waits on the other's ready
  assign o_cmt_valid  = vld_q & (need_wbck ? i_wbck_ready : 1'b1);
  assign o_wbck_valid = vld_q & need_wbck & i_cmt_ready;

  assign retire  = vld_q & i_cmt_ready & (need_wbck ? i_wbck_ready : 1'b1);
  // Free slot or slot draining this cycle
  assign o_ready = ~vld_q | retire;
  assign accept  = i_valid & o_ready;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      vld_q <= 1'b0;
    end else if (accept) begin
      vld_q <= 1'b1;
    end else if (retire) begin
      vld_q <= 1'b0;
    end
  end

  // Entry payload, loaded only on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      rdwen_q        <= i_rdwen;
      excp_q         <= i_excp;
      o_wbck_wdat    <= wdat;
      o_wbck_rdidx   <= i_rdidx;
      o_cmt_pc       <= i_pc;
      o_cmt_pc_vld   <= i_pc_vld;
      o_cmt_imm      <= i_imm;
      o_cmt_bjp      <= i_bjp_cmt;
      o_cmt_bjp_prdt <= i_bjp_prdt;
      o_cmt_bjp_rslv <= i_bjp_rslv;
    end
  end

  assign o_cmt_ilegl = excp_q;

endmodule

/* src/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu (
  input  logic              clk,
  input  logic              i_rst_n,
  // Dispatch side
  input  logic              i_valid,
  output logic              o_ready,
  input  alu_pkg::xlen_t    i_rs1,
  input  alu_pkg::xlen_t    i_rs2,
  input  alu_pkg::xlen_t    i_imm,
  input  alu_pkg::decinfo_t i_info,
  input  alu_pkg::pc_t      i_pc,
  input  logic              i_pc_vld,
  input  alu_pkg::rfidx_t   i_rdidx,
  input  logic              i_rdwen,
  input  logic              i_ilegl,
  // Commit channel
  output logic              o_cmt_valid,
  input  logic              i_cmt_ready,
  output logic              o_cmt_pc_vld,
  output alu_pkg::pc_t      o_cmt_pc,
  output alu_pkg::xlen_t    o_cmt_imm,
  output logic              o_cmt_bjp,
  output logic              o_cmt_bjp_prdt,
  output logic              o_cmt_bjp_rslv,
  output logic              o_cmt_ilegl,
  // Write-back channel
  output logic              o_wbck_valid,
  input  logic              i_wbck_ready,
  output alu_pkg::xlen_t    o_wbck_wdat,
  output alu_pkg::rfidx_t   o_wbck_rdidx
);

  logic           alu_sel;
  logic           bjp_sel;
  logic           excp;
  alu_pkg::xlen_t alu_rs1;
  alu_pkg::xlen_t alu_rs2;
  alu_pkg::xlen_t alu_imm;
  alu_pkg::xlen_t bjp_rs1;
  alu_pkg::xlen_t bjp_rs2;
  alu_pkg::pc_t   bjp_pc;
  alu_pkg::xlen_t alu_wdat;
  alu_pkg::xlen_t bjp_wdat;
  logic           bjp_cmt;
  logic           bjp_prdt;
  logic           bjp_rslv;

  // Unit to datapath links
  alu_req_if alu_req ();
  alu_req_if bjp_req ();

  ////////////////////////////////////////////////////////////
  // Dispatch and units
  ////////////////////////////////////////////////////////////
  alu_dispatch alu_dispatch_i (
    .i_info    (i_info),
    .i_ilegl   (i_ilegl),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_imm     (i_imm),
    .i_pc      (i_pc),
    .o_alu_sel (alu_sel),
    .o_bjp_sel (bjp_sel),
    .o_excp    (excp),
    .o_alu_rs1 (alu_rs1),
    .o_alu_rs2 (alu_rs2),
    .o_alu_imm (alu_imm),
    .o_bjp_rs1 (bjp_rs1),
    .o_bjp_rs2 (bjp_rs2),
    .o_bjp_pc  (bjp_pc)
  );

  // Both units read the same op field
  alu_rglr alu_rglr_i (
    .i_sel    (alu_sel),
    .i_code   (i_info[alu_pkg::DECINFO_OP_LSB +: alu_pkg::DECINFO_OP_W]),
    .i_op2imm (i_info[alu_pkg::DECINFO_OP2IMM]),
    .i_rs1    (alu_rs1),
    .i_rs2    (alu_rs2),
    .i_imm    (alu_imm),
    .o_req    (alu_req.requester),
    .o_wdat   (alu_wdat)
  );

  alu_bjp alu_bjp_i (
    .i_sel      (bjp_sel),
    .i_code     (i_info[alu_pkg::DECINFO_OP_LSB +: alu_pkg::DECINFO_OP_W]),
    .i_prdt     (i_info[alu_pkg::DECINFO_BPRDT]),
    .i_rs1      (bjp_rs1),
    .i_rs2      (bjp_rs2),
    .i_pc       (bjp_pc),
    .o_req      (bjp_req.requester),
    .o_wdat     (bjp_wdat),
    .o_cmt_bjp  (bjp_cmt),
    .o_cmt_prdt (bjp_prdt),
    .o_cmt_rslv (bjp_rslv)
  );

  alu_dpath alu_dpath_i (
    .i_alu (alu_req.dpath),
    .i_bjp (bjp_req.dpath)
  );

  ////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////
  alu_wbck_cmt alu_wbck_cmt_i (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_valid        (i_valid),
    .o_ready        (o_ready),
    .i_alu_sel      (alu_sel),
    .i_bjp_sel      (bjp_sel),
    .i_excp         (excp),
    .i_alu_wdat     (alu_wdat),
    .i_bjp_wdat     (bjp_wdat),
    .i_bjp_cmt      (bjp_cmt),
    .i_bjp_prdt     (bjp_prdt),
    .i_bjp_rslv     (bjp_rslv),
    .i_rdwen        (i_rdwen),
    .i_rdidx        (i_rdidx),
    .i_pc           (i_pc),
    .i_pc_vld       (i_pc_vld),
    .i_imm          (i_imm),
    .o_cmt_valid    (o_cmt_valid),
    .i_cmt_ready    (i_cmt_ready),
    .o_cmt_pc_vld   (o_cmt_pc_vld),
    .o_cmt_pc       (o_cmt_pc),
    .o_cmt_imm      (o_cmt_imm),
    .o_cmt_bjp      (o_cmt_bjp),
    .o_cmt_bjp_prdt (o_cmt_bjp_prdt),
    .o_cmt_bjp_rslv (o_cmt_bjp_rslv),
    .o_cmt_ilegl    (o_cmt_ilegl),
    .o_wbck_valid   (o_wbck_valid),
    .i_wbck_ready   (i_wbck_ready),
    .o_wbck_wdat    (o_wbck_wdat),
    .o_wbck_rdidx   (o_wbck_rdidx)
  );

endmodule

/* tb/exu_alu_checker.sv */
`timescale 1ns/1ps

module exu_alu_checker (
  input logic            clk,
  input logic            i_rst_n,
  input logic            o_ready,
  input logic            o_cmt_valid,
  input logic            i_cmt_ready,
  input logic            o_cmt_ilegl,
  input alu_pkg::pc_t    o_cmt_pc,
  input alu_pkg::xlen_t  o_cmt_imm,
  input logic            o_wbck_valid,
  input alu_pkg::xlen_t  o_wbck_wdat,
  input alu_pkg::rfidx_t o_wbck_rdidx
);

  ////////////////////////////////////////////////////////////
  // Reset and handshake rules
  ////////////////////////////////////////////////////////////
  // Stage empty and open once reset has been seen
  reset_state_a: assert property (@(posedge clk)
    !i_rst_n |=> (!o_cmt_valid && !o_wbck_valid && o_ready))
    else $error("output stage not empty after reset");

  // Write-back only together with a ready commit side, never for an exception
  wbck_joint_a: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_wbck_valid |-> (i_cmt_ready && !o_cmt_ilegl))
    else $error("write-back valid without commit ready");

  // Waiting entry holds its payload
  entry_stable_a: assert property (@(posedge clk) disable iff (!i_rst_n)
    !o_ready |=> ($stable(o_cmt_pc) && $stable(o_cmt_imm) && $stable(o_cmt_ilegl)
                  && $stable(o_wbck_wdat) && $stable(o_wbck_rdidx)))
    else $error("entry changed while stalled");

endmodule

bind exu_alu exu_alu_checker exu_alu_checker_i (.*);

/* tb/tb_exu_alu.sv */
`timescale 1ns/1ps

module tb_exu_alu;

  localparam int CLK_PERIOD = 8;
  localparam int N_TXN      = 400;

  // Expected contents of one retiring entry
  typedef struct packed {
    logic [31:0] wdat;
    logic [4:0]  rdidx;
    logic [31:0] pc;
    logic        pc_vld;
    logic [31:0] imm;
    logic        bjp;
    logic        prdt;
    logic        rslv;
    logic        ilegl;
    logic        wb;
  } exp_t;

  logic              clk;
  logic              i_rst_n;
  logic              i_valid;
  logic              o_ready;
  alu_pkg::xlen_t    i_rs1;
  alu_pkg::xlen_t    i_rs2;
  alu_pkg::xlen_t    i_imm;
  alu_pkg::decinfo_t i_info;
  alu_pkg::pc_t      i_pc;
  logic              i_pc_vld;
  alu_pkg::rfidx_t   i_rdidx;
  logic              i_rdwen;
  logic              i_ilegl;
  logic              o_cmt_valid;
  logic              i_cmt_ready;
  logic              o_cmt_pc_vld;
  alu_pkg::pc_t      o_cmt_pc;
  alu_pkg::xlen_t    o_cmt_imm;
  logic              o_cmt_bjp;
  logic              o_cmt_bjp_prdt;
  logic              o_cmt_bjp_rslv;
  logic              o_cmt_ilegl;
  logic              o_wbck_valid;
  logic              i_wbck_ready;
  alu_pkg::xlen_t    o_wbck_wdat;
  alu_pkg::rfidx_t   o_wbck_rdidx;

  logic [31:0] lfsr;
  exp_t        exp_q[$];
  int          sent;
  int          retired;

  exu_alu exu_alu_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic exp_t predict(logic [7:0] info, logic [31:0] a, logic [31:0] rs2,
                                   logic [31:0] imm, logic [31:0] pc, logic pc_vld,
                                   logic [4:0] rd, logic rdwen, logic ilegl);
    exp_t        e;
    logic [3:0]  code;
    logic [31:0] b;
    code     = info[5:2];
    // Bit 6 picks the immediate as second operand
    b        = info[6] ? imm : rs2;
    e        = '0;
    e.rdidx  = rd;
    e.pc     = pc;
    e.pc_vld = pc_vld;
    e.imm    = imm;
    // Groups 2 and 3 are reserved
    e.ilegl  = ilegl | info[1];
    e.wb     = rdwen & ~e.ilegl;
    if (e.ilegl) begin
      e.wdat = '0;
    end else if (info[1:0] == 2'd1) begin
      e.bjp  = 1'b1;
      e.prdt = info[7];
      e.wdat = pc + 32'd4;
      case (code)
        alu_pkg::BJP_BEQ:  e.rslv = (a == rs2);
        alu_pkg::BJP_BNE:  e.rslv = (a != rs2);
        alu_pkg::BJP_BLT:  e.rslv = ($signed(a) < $signed(rs2));
        alu_pkg::BJP_BGE:  e.rslv = ($signed(a) >= $signed(rs2));
        alu_pkg::BJP_BLTU: e.rslv = (a < rs2);
        alu_pkg::BJP_BGEU: e.rslv = (a >= rs2);
        default:           e.rslv = 1'b1;
      endcase
    end else begin
      case (code)
        alu_pkg::ALU_SUB:  e.wdat = a - b;
        alu_pkg::ALU_XOR:  e.wdat = a ^ b;
        alu_pkg::ALU_SLL:  e.wdat = a << b[4:0];
        alu_pkg::ALU_SRL:  e.wdat = a >> b[4:0];
        alu_pkg::ALU_SRA:  e.wdat = $signed(a) >>> b[4:0];
        alu_pkg::ALU_OR:   e.wdat = a | b;
        alu_pkg::ALU_AND:  e.wdat = a & b;
        alu_pkg::ALU_SLT:  e.wdat = {31'd0, $signed(a) < $signed(b)};
        alu_pkg::ALU_SLTU: e.wdat = {31'd0, a < b};
        alu_pkg::ALU_LUI:  e.wdat = imm;
        // Add and unused codes
        default:           e.wdat = a + b;
      endcase
    end
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // Error reporting
  ////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic report_error(string what);
    $display("Error: %s", what);
    abort_run();
  endtask

  task automatic check_reset_state();
    check_value("o_cmt_valid", 32'(o_cmt_valid), 32'd0);
    check_value("o_wbck_valid", 32'(o_wbck_valid), 32'd0);
    check_value("o_ready", 32'(o_ready), 32'd1);
  endtask

  ////////////////////////////////////////////////////////////
  // Per-edge scoreboard and stimulus
  ////////////////////////////////////////////////////////////
  // Reads the values that settled before this edge
  task automatic scoreboard_edge();
    logic busy;
    logic head_wb;
    logic retire;
    exp_t e;
    busy    = (exp_q.size() != 0);
    head_wb = 1'b0;
    if (busy) begin
      head_wb = exp_q[0].wb;
    end
    // Joint rule, each channel waits on the other's ready
    retire = busy && i_cmt_ready && (!head_wb || i_wbck_ready);
    check_value("o_cmt_valid", 32'(o_cmt_valid), 32'(busy && (!head_wb || i_wbck_ready)));
    check_value("o_wbck_valid", 32'(o_wbck_valid), 32'(head_wb && i_cmt_ready));
    // Ready when empty or draining
    check_value("o_ready", 32'(o_ready), 32'(!busy || retire));
    if (retire) begin
      e = exp_q.pop_front();
      check_value("o_cmt_pc", o_cmt_pc, e.pc);
      check_value("o_cmt_pc_vld", 32'(o_cmt_pc_vld), 32'(e.pc_vld));
      check_value("o_cmt_imm", o_cmt_imm, e.imm);
      check_value("o_cmt_bjp", 32'(o_cmt_bjp), 32'(e.bjp));
      check_value("o_cmt_bjp_prdt", 32'(o_cmt_bjp_prdt), 32'(e.prdt));
      check_value("o_cmt_bjp_rslv", 32'(o_cmt_bjp_rslv), 32'(e.rslv));
      check_value("o_cmt_ilegl", 32'(o_cmt_ilegl), 32'(e.ilegl));
      check_value("o_wbck_wdat", o_wbck_wdat, e.wdat);
      check_value("o_wbck_rdidx", 32'(o_wbck_rdidx), 32'(e.rdidx));
      retired++;
    end
    if (i_valid && o_ready) begin
      exp_q.push_back(predict(i_info, i_rs1, i_rs2, i_imm, i_pc, i_pc_vld,
                              i_rdidx, i_rdwen, i_ilegl));
      sent++;
    end
  endtask

  task automatic drive_inputs();
    logic [3:0]  g;
    logic [1:0]  grp;
    logic [31:0] rs1;
    // Ready inputs high three times in four
    i_cmt_ready  <= take_bits(2) != 32'd0;
    i_wbck_ready <= take_bits(2) != 32'd0;
    // Stalled instruction stays on the bus
    if (i_valid && !o_ready) begin
      return;
    end
    if (sent >= N_TXN) begin
      i_valid <= 1'b0;
      return;
    end
    // Mostly ALU, some branches, a few reserved groups
    g   = 4'(take_bits(4));
    grp = (g < 4'd7) ? 2'd0 : (g < 4'd13) ? 2'd1 : {1'b1, g[0]};
    rs1 = take_bits(32);
    i_valid  <= take_bits(2) != 32'd0;
    i_rs1    <= rs1;
    // Equal operands now and then for beq and bne
    i_rs2    <= (take_bits(2) == 32'd0) ? rs1 : take_bits(32);
    i_imm    <= take_bits(32);
    i_info   <= {2'(take_bits(2)), 4'(take_bits(4)), grp};
    i_pc     <= take_bits(32);
    i_pc_vld <= take_bits(1) != 32'd0;
    i_rdidx  <= 5'(take_bits(5));
    i_rdwen  <= take_bits(2) != 32'd0;
    i_ilegl  <= take_bits(5) == 32'd0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    clk          = 1'b0;
    i_rst_n      = 1'b0;
    i_valid      = 1'b0;
    i_rs1        = '0;
    i_rs2        = '0;
    i_imm        = '0;
    i_info       = '0;
    i_pc         = '0;
    i_pc_vld     = 1'b0;
    i_rdidx      = '0;
    i_rdwen      = 1'b0;
    i_ilegl      = 1'b0;
    i_cmt_ready  = 1'b0;
    i_wbck_ready = 1'b0;
    lfsr         = 32'h1d68cda9;
    sent         = 0;
    retired      = 0;
    repeat (9) @(posedge clk);
    // Still in reset
    @(negedge clk);
    check_reset_state();
    @(posedge clk);
    i_rst_n <= 1'b1;
    // First cycle out of reset
    @(negedge clk);
    check_reset_state();
    while (retired < N_TXN) begin
      @(posedge clk);
      scoreboard_edge();
      drive_inputs();
    end
    $display("Simulation finished: PASS");
    $finish;
  end

  // Twenty cycles per instruction plus reset
  initial begin
    #(CLK_PERIOD * (20 * N_TXN + 20));
    report_error("watchdog expired before all instructions retired");
  end

endmodule

/* list.f */
src/alu_pkg.sv
src/alu_req_if.sv
src/alu_dispatch.sv
src/alu_rglr.sv
src/alu_bjp.sv
src/alu_dpath.sv
src/alu_wbck_cmt.sv
src/exu_alu.sv
tb/exu_alu_checker.sv
tb/tb_exu_alu.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_exu_alu -f list.f -o sim_exu_alu \
  && ./obj_dir/sim_exu_alu > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log 2>/dev/null && echo "run.sh: passed" \
  || { echo "run.sh: failed"; exit 1; }
